// File: pong_stimulus.txt
# ticks keys(right up_n, right down_n, left up_n, left down_n) start exp_left exp_right home
# keys are active low, home=1 checks an idle frame with ball and paddles at home
29 0111 1 1 0 0
4 1111 0 1 0 1
1 1111 1 1 0 0
200 1111 0 1 0 0
150 1110 0 1 1 1
2900 0111 1 101 1 0
10353 0111 1 458 1 0
15689 0111 1 999 1 0
87 0111 1 2 1 0
3948 1110 1 2 48 0
4 1111 0 2 48 1

// File: pong.f
pong_pkg.sv
raster_scan.sv
paddle_ctrl.sv
ball_ctrl.sv
scoreboard.sv
pixel_render.sv
pong_top.sv
tb_pong.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_pong -f pong.f \
	&& ./obj_dir/Vtb_pong | tee /dev/stderr | grep -q "STATUS: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb_pong.sv
`default_nettype none

module tb_pong;
	import pong_pkg::*;

	// reduced geometry keeps a frame at 6600 clocks
	localparam int H_ACT = 80;
	localparam int H_FP = 4;
	localparam int H_SW = 8;
	localparam int H_TOT = 100;
	localparam int V_ACT = 60;
	localparam int V_FP = 2;
	localparam int V_SW = 2;
	localparam int V_TOT = 66;
	localparam int BALL_R = 1;
	localparam int PAD_HH = 8;
	localparam int PAD_HW = 2;
	localparam int ZONE = 3;
	localparam int RIGHT_X = 70;
	localparam int LEFT_X = 10;
	localparam int CLK_PERIOD = 4;
	localparam int TICK_CLOCKS = 8;
	localparam int FRAME_CLOCKS = H_TOT * V_TOT;
	localparam int MAX_GAP = 17;

	typedef struct packed {
		int ticks;
		logic [3:0] keys; // right up, right down, left up, left down
		logic start;
		int exp_left;
		int exp_right;
		logic home; // idle frame with everything at home follows
	} phase_t;

	logic clk_mov;
	logic rst_vga;
	logic move_tick;
	logic start;
	paddle_keys_t keys_right;
	paddle_keys_t keys_left;
	sync_t sync;
	logic pixel;
	seg_t [5:0] hex;

	phase_t phases[$];
	int edge_count;
	int checks;
	int errors;
	int sx;
	int sy;
	int unsigned rand_state;
	logic phases_loaded = 1'b0;
	longint watchdog_clocks;

	pong_top #(
		.H_ACTIVE(H_ACT), .H_FRONT(H_FP), .H_SYNC(H_SW), .H_TOTAL(H_TOT),
		.V_ACTIVE(V_ACT), .V_FRONT(V_FP), .V_SYNC(V_SW), .V_TOTAL(V_TOT),
		.BALL_HALF(BALL_R), .PADDLE_HALF_H(PAD_HH), .PADDLE_HALF_W(PAD_HW),
		.PADDLE_ZONE(ZONE), .RIGHT_PADDLE_X(RIGHT_X), .LEFT_PADDLE_X(LEFT_X),
		.SCORE_DIGITS(3)
	) dut (
		.clk_mov(clk_mov), .rst_vga(rst_vga), .move_tick(move_tick), .start(start),
		.keys_right(keys_right), .keys_left(keys_left), .sync(sync), .pixel(pixel),
		.hex(hex)
	);

	always #(CLK_PERIOD / 2) clk_mov = ~clk_mov;

	// clocks since reset release
	always @(posedge clk_mov) begin
		if (rst_vga)
			edge_count <= 0;
		else
			edge_count <= edge_count + 1;
	end

	function automatic int unsigned lcg_step(input int unsigned state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [6:0] digit_segments(input int digit);
		case (digit)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			9: return 7'b0011000; // nine drawn without the bottom bar
			default: return 7'b1111111;
		endcase
	endfunction

	function automatic bit in_rect(input int x, input int y, input int cx, input int cy,
		input int hw, input int hh);
		return x >= cx - hw && x < cx + hw && y >= cy - hh && y < cy + hh;
	endfunction

	// ball at centre, both paddles at half height
	function automatic bit home_pixel(input int x, input int y);
		if (x >= H_ACT || y >= V_ACT)
			return 1'b0;
		return in_rect(x, y, H_ACT / 2, V_ACT / 2, BALL_R, BALL_R) ||
			in_rect(x, y, RIGHT_X, V_ACT / 2, PAD_HW, PAD_HH) ||
			in_rect(x, y, LEFT_X, V_ACT / 2, PAD_HW, PAD_HH);
	endfunction

	task automatic check_value(input string name, input int unsigned got,
		input int unsigned exp);
		checks++;
		assert (got == exp) else begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic load_phases();
		int fd;
		int code;
		int ticks;
		int start_bit;
		int left;
		int right;
		int home;
		int total;
		int homes;
		logic [3:0] keys;
		string line;
		phase_t p;
		total = 0;
		homes = 0;
		fd = $fopen("pong_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open pong_stimulus.txt for reading");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0) begin
					code = $sscanf(line, "%d %b %d %d %d %d", ticks, keys, start_bit,
						left, right, home);
					if (code == 6) begin
						p.ticks = ticks;
						p.keys = keys;
						p.start = start_bit[0];
						p.exp_left = left;
						p.exp_right = right;
						p.home = home[0];
						phases.push_back(p);
						total += ticks;
						homes += home;
					end else if (line.len() > 1 && line.getc(0) != "#") begin
						$display("stimulus line could not be parsed: %s", line);
						errors++;
					end
				end
			end
			$fclose(fd);
		end
		if (phases.size() == 0) begin
			$display("the stimulus file gave no phases to run");
			errors++;
		end
		watchdog_clocks = longint'(total) * TICK_CLOCKS + phases.size() * (MAX_GAP + 2) +
			(homes + 1) * FRAME_CLOCKS + 1000;
		phases_loaded = 1'b1;
	endtask

	task automatic check_reset_state();
		check_value("sync", sync, 2'b11);
		check_value("pixel", pixel, 0);
		for (int d = 0; d < 6; d++)
			check_value($sformatf("hex[%0d]", d), hex[d], digit_segments(0));
	endtask

	// pixel lags the raster by one clock
	task automatic check_frame();
		int n;
		repeat (FRAME_CLOCKS) begin
			@(negedge clk_mov);
			n = edge_count - 1;
			check_value("pixel", pixel, home_pixel(n % H_TOT, (n / H_TOT) % V_TOT));
		end
	endtask

	task automatic run_phase(input phase_t p);
		keys_right = p.keys[3:2];
		keys_left = p.keys[1:0];
		start = p.start;
		repeat (p.ticks) begin
			move_tick = 1'b1;
			@(negedge clk_mov);
			move_tick = 1'b0;
			repeat (TICK_CLOCKS - 1) @(negedge clk_mov);
		end
		keys_right = '1; // all keys released
		keys_left = '1;
		start = 1'b0;
	endtask

	task automatic check_scores(input int left, input int right);
		int div;
		div = 1;
		for (int d = 0; d < 3; d++) begin
			check_value($sformatf("hex[%0d]", d), hex[d], digit_segments((right / div) % 10));
			check_value($sformatf("hex[%0d]", d + 3), hex[d + 3],
				digit_segments((left / div) % 10));
			div = div * 10;
		end
	endtask

	// sync pulses follow the raster position of the previous clock
	always @(negedge clk_mov) begin
		if (!rst_vga && edge_count > 0) begin
			sx = (edge_count - 1) % H_TOT;
			sy = ((edge_count - 1) / H_TOT) % V_TOT;
			check_value("sync.hsync", sync.hsync,
				!(sx >= H_ACT + H_FP && sx < H_ACT + H_FP + H_SW));
			check_value("sync.vsync", sync.vsync,
				!(sy >= V_ACT + V_FP && sy < V_ACT + V_FP + V_SW));
		end
	end

	initial begin
		wait (phases_loaded);
		#(watchdog_clocks * CLK_PERIOD);
		$display("watchdog expired before the phases were done");
		$display("checks: %0d errors: %0d", checks, errors + 1);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		clk_mov = 1'b0;
		rst_vga = 1'b1;
		move_tick = 1'b0;
		start = 1'b0;
		keys_right = '1;
		keys_left = '1;
		checks = 0;
		errors = 0;
		rand_state = 32'd84;
		load_phases();
		repeat (8) @(negedge clk_mov);
		check_reset_state();
		rst_vga = 1'b0;
		check_frame(); // game idle after reset
		foreach (phases[i]) begin
			rand_state = lcg_step(rand_state);
			repeat (2 + (rand_state >> 16) % 16) @(negedge clk_mov);
			run_phase(phases[i]);
			check_scores(phases[i].exp_left, phases[i].exp_right);
			if (phases[i].home)
				check_frame();
		end
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: pong_top.sv
`default_nettype none

module pong_top #(
	parameter int H_ACTIVE = pong_pkg::H_ACTIVE,
	parameter int H_FRONT = pong_pkg::H_FRONT,
	parameter int H_SYNC = pong_pkg::H_SYNC,
	parameter int H_TOTAL = pong_pkg::H_TOTAL,
	parameter int V_ACTIVE = pong_pkg::V_ACTIVE,
	parameter int V_FRONT = pong_pkg::V_FRONT,
	parameter int V_SYNC = pong_pkg::V_SYNC,
	parameter int V_TOTAL = pong_pkg::V_TOTAL,
	parameter int BALL_HALF = pong_pkg::BALL_HALF,
	parameter int PADDLE_HALF_H = pong_pkg::PADDLE_HALF_H,
	parameter int PADDLE_HALF_W = pong_pkg::PADDLE_HALF_W,
	parameter int PADDLE_ZONE = pong_pkg::PADDLE_ZONE,
	parameter int RIGHT_PADDLE_X = pong_pkg::RIGHT_PADDLE_X,
	parameter int LEFT_PADDLE_X = pong_pkg::LEFT_PADDLE_X,
	parameter int SCORE_DIGITS = pong_pkg::SCORE_DIGITS
) (
	input logic clk_mov,
	input logic rst_vga,
	input logic move_tick, // game step strobe
	input logic start,
	input pong_pkg::paddle_keys_t keys_right,
	input pong_pkg::paddle_keys_t keys_left,
	output pong_pkg::sync_t sync,
	output logic pixel,
	output pong_pkg::seg_t [2*SCORE_DIGITS-1:0] hex
);
	import pong_pkg::*;

	pos_t raster;
	pos_t ball;
	logic active;
	logic running;
	coord_t right_y;
	coord_t left_y;
	logic point_left;
	logic point_right;

	raster_scan #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_TOTAL(H_TOTAL),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_TOTAL(V_TOTAL)
	) u_raster (
		.clk_mov(clk_mov), .rst_vga(rst_vga), .raster(raster), .active(active), .sync(sync)
	);

	paddle_ctrl #(.V_ACTIVE(V_ACTIVE), .PADDLE_HALF_H(PADDLE_HALF_H)) u_paddle_right (
		.clk_mov(clk_mov), .rst_vga(rst_vga), .move_tick(move_tick), .running(running),
		.keys(keys_right), .paddle_y(right_y)
	);

	paddle_ctrl #(.V_ACTIVE(V_ACTIVE), .PADDLE_HALF_H(PADDLE_HALF_H)) u_paddle_left (
		.clk_mov(clk_mov), .rst_vga(rst_vga), .move_tick(move_tick), .running(running),
		.keys(keys_left), .paddle_y(left_y)
	);

	ball_ctrl #(
		.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .BALL_HALF(BALL_HALF),
		.PADDLE_HALF_H(PADDLE_HALF_H), .PADDLE_HALF_W(PADDLE_HALF_W),
		.PADDLE_ZONE(PADDLE_ZONE), .RIGHT_PADDLE_X(RIGHT_PADDLE_X),
		.LEFT_PADDLE_X(LEFT_PADDLE_X)
	) u_ball (
		.clk_mov(clk_mov), .rst_vga(rst_vga), .move_tick(move_tick), .start(start),
		.right_y(right_y), .left_y(left_y), .running(running), .ball(ball),
		.point_left(point_left), .point_right(point_right)
	);

	scoreboard #(.SCORE_DIGITS(SCORE_DIGITS)) u_score (
		.clk_mov(clk_mov), .rst_vga(rst_vga), .point_left(point_left),
		.point_right(point_right), .hex(hex)
	);

	pixel_render #(
		.BALL_HALF(BALL_HALF), .PADDLE_HALF_H(PADDLE_HALF_H), .PADDLE_HALF_W(PADDLE_HALF_W),
		.RIGHT_PADDLE_X(RIGHT_PADDLE_X), .LEFT_PADDLE_X(LEFT_PADDLE_X)
	) u_render (
		.clk_mov(clk_mov), .rst_vga(rst_vga), .active(active), .raster(raster),
		.ball(ball), .right_y(right_y), .left_y(left_y), .pixel(pixel)
	);

endmodule

`default_nettype wire

// File: pixel_render.sv
`default_nettype none

module pixel_render #(
	parameter int BALL_HALF = 4,
	parameter int PADDLE_HALF_H = 42,
	parameter int PADDLE_HALF_W = 2,
	parameter int RIGHT_PADDLE_X = 580,
	parameter int LEFT_PADDLE_X = 60
) (
	input logic clk_mov,
	input logic rst_vga,
	input logic active,
	input pong_pkg::pos_t raster,
	input pong_pkg::pos_t ball,
	input pong_pkg::coord_t right_y,
	input pong_pkg::coord_t left_y,
	output logic pixel
);
	import pong_pkg::*;

	logic on_ball;
	logic on_right;
	logic on_left;

	// point within [c - half, c + half) on both axes
	function automatic logic in_box(input pos_t p, input pos_t c, input int half_w,
		input int half_h);
		return (p.x + half_w >= c.x) && (p.x < c.x + half_w) &&
			(p.y + half_h >= c.y) && (p.y < c.y + half_h);
	endfunction

	assign on_ball = in_box(raster, ball, BALL_HALF, BALL_HALF);
	assign on_right = in_box(raster, '{x: coord_t'(RIGHT_PADDLE_X), y: right_y},
		PADDLE_HALF_W, PADDLE_HALF_H);
	assign on_left = in_box(raster, '{x: coord_t'(LEFT_PADDLE_X), y: left_y},
		PADDLE_HALF_W, PADDLE_HALF_H);

	always_ff @(posedge clk_mov) begin
		if (rst_vga)
			pixel <= 1'b0;
		else
			pixel <= active && (on_ball || on_right || on_left); // white on black
	end

endmodule

`default_nettype wire

// File: scoreboard.sv
`default_nettype none

module scoreboard #(
	parameter int SCORE_DIGITS = 3
) (
	input logic clk_mov,
	input logic rst_vga,
	input logic point_left,
	input logic point_right,
	output pong_pkg::seg_t [2*SCORE_DIGITS-1:0] hex
);
	import pong_pkg::*;

	localparam int SCORE_MAX = 10 ** SCORE_DIGITS - 1;
	localparam int BCD_W = 4 * SCORE_DIGITS;

	score_t left_score;
	score_t right_score;
	logic [BCD_W-1:0] left_bcd;
	logic [BCD_W-1:0] right_bcd;

	// shift-and-add-3 over every bit of the count
	function automatic logic [BCD_W-1:0] to_bcd(input score_t bin);
		logic [BCD_W-1:0] bcd;
		bcd = '0;
		for (int i = $bits(score_t) - 1; i >= 0; i--) begin
			for (int d = 0; d < SCORE_DIGITS; d++) begin
				if (bcd[4*d +: 4] >= 4'd5)
					bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
			end
			bcd = {bcd[BCD_W-2:0], bin[i]};
		end
		return bcd;
	endfunction

	always_ff @(posedge clk_mov) begin
		if (rst_vga) begin
			left_score <= '0;
			right_score <= '0;
		end else begin
			if (point_left)
				left_score <= (left_score == score_t'(SCORE_MAX)) ? '0 : left_score + 1'b1;
			if (point_right)
				right_score <= (right_score == score_t'(SCORE_MAX)) ? '0 : right_score + 1'b1;
		end
	end

	assign left_bcd = to_bcd(left_score);
	assign right_bcd = to_bcd(right_score);

	for (genvar d = 0; d < SCORE_DIGITS; d++) begin : g_digit
		assign hex[d] = seg_encode(right_bcd[4*d +: 4]); // right side on the low digits
		assign hex[d + SCORE_DIGITS] = seg_encode(left_bcd[4*d +: 4]);
	end

endmodule

`default_nettype wire

// File: ball_ctrl.sv
`default_nettype none

module ball_ctrl #(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480,
	parameter int BALL_HALF = 4,
	parameter int PADDLE_HALF_H = 42,
	parameter int PADDLE_HALF_W = 2,
	parameter int PADDLE_ZONE = 14,
	parameter int RIGHT_PADDLE_X = 580,
	parameter int LEFT_PADDLE_X = 60
) (
	input logic clk_mov,
	input logic rst_vga,
	input logic move_tick,
	input logic start,
	input pong_pkg::coord_t right_y,
	input pong_pkg::coord_t left_y,
	output logic running,
	output pong_pkg::pos_t ball,
	output logic point_left,
	output logic point_right
);
	import pong_pkg::*;

	typedef enum logic [1:0] {
		SLOPE_LEVEL,
		SLOPE_UP,
		SLOPE_DOWN
	} slope_e;

	localparam pos_t CENTRE = '{x: coord_t'(H_ACTIVE / 2), y: coord_t'(V_ACTIVE / 2)};
	localparam int RIGHT_FACE = RIGHT_PADDLE_X - PADDLE_HALF_W;
	localparam int LEFT_FACE = LEFT_PADDLE_X + PADDLE_HALF_W;

	logic dir_right; // horizontal direction
	slope_e slope;
	coord_t pad_y; // paddle the ball is heading for
	logic at_face;
	logic overlap;
	slope_e zone_slope;

	always_comb begin
		pad_y = dir_right ? right_y : left_y;
		if (dir_right)
			at_face = (ball.x + BALL_HALF >= RIGHT_FACE);
		else
			at_face = (ball.x <= LEFT_FACE + BALL_HALF);
		// half-open spans of ball and paddle intersect
		overlap = (ball.y < pad_y + PADDLE_HALF_H + BALL_HALF) &&
			(pad_y < ball.y + PADDLE_HALF_H + BALL_HALF);
		if (ball.y + PADDLE_ZONE < pad_y)
			zone_slope = SLOPE_UP; // top third
		else if (ball.y >= pad_y + PADDLE_ZONE)
			zone_slope = SLOPE_DOWN; // bottom third
		else
			zone_slope = SLOPE_LEVEL;
	end

	always_ff @(posedge clk_mov) begin
		point_left <= 1'b0; // strobes last one clock
		point_right <= 1'b0;
		if (rst_vga) begin
			running <= 1'b0;
			dir_right <= 1'b1;
			slope <= SLOPE_LEVEL;
			ball <= CENTRE;
		end else if (move_tick) begin
			if (!running) begin
				ball <= CENTRE;
				if (start) begin
					running <= 1'b1;
					dir_right <= 1'b1; // serve to the right
					slope <= SLOPE_LEVEL;
				end
			end else if (at_face) begin
				if (overlap) begin
					dir_right <= !dir_right;
					slope <= zone_slope;
				end else begin
					running <= 1'b0; // rally over
					ball <= CENTRE;
					point_left <= dir_right;
					point_right <= !dir_right;
				end
			end else begin
				ball.x <= dir_right ? ball.x + 1'b1 : ball.x - 1'b1;
				case (slope)
					SLOPE_UP: begin
						if (ball.y > BALL_HALF)
							ball.y <= ball.y - 1'b1;
						else
							slope <= SLOPE_DOWN; // top wall
					end
					SLOPE_DOWN: begin
						if (ball.y + BALL_HALF < V_ACTIVE)
							ball.y <= ball.y + 1'b1;
						else
							slope <= SLOPE_UP; // bottom wall
					end
					default: begin
						slope <= SLOPE_LEVEL;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: paddle_ctrl.sv
`default_nettype none

module paddle_ctrl #(
	parameter int V_ACTIVE = 480,
	parameter int PADDLE_HALF_H = 42
) (
	input logic clk_mov,
	input logic rst_vga,
	input logic move_tick,
	input logic running,
	input pong_pkg::paddle_keys_t keys,
	output pong_pkg::coord_t paddle_y
);
	import pong_pkg::*;

	localparam coord_t HOME_Y = coord_t'(V_ACTIVE / 2);

	logic can_down;
	logic can_up;
	coord_t next_y;

	// both keys judged against the current position
	always_comb begin
		can_down = !keys.down_n && (paddle_y + PADDLE_HALF_H < V_ACTIVE);
		can_up = !keys.up_n && (paddle_y > PADDLE_HALF_H); // top edge above 0
		next_y = paddle_y;
		if (can_down)
			next_y = next_y + coord_t'(2);
		if (can_up)
			next_y = next_y - coord_t'(2);
	end

	always_ff @(posedge clk_mov) begin
		if (rst_vga) begin
			paddle_y <= HOME_Y;
		end else if (move_tick) begin
			paddle_y <= running ? next_y : HOME_Y; // idle game parks paddle
		end
	end

endmodule

`default_nettype wire

// File: raster_scan.sv
`default_nettype none

module raster_scan #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_TOTAL = 800,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_TOTAL = 525
) (
	input logic clk_mov,
	input logic rst_vga,
	output pong_pkg::pos_t raster,
	output logic active,
	output pong_pkg::sync_t sync
);
	import pong_pkg::*;

	localparam int HS_START = H_ACTIVE + H_FRONT;
	localparam int VS_START = V_ACTIVE + V_FRONT;

	logic col_wrap;

	assign col_wrap = (raster.x == coord_t'(H_TOTAL - 1));

	always_ff @(posedge clk_mov) begin
		if (rst_vga) begin
			raster <= '0;
			sync <= '1; // both syncs idle high
		end else begin
			if (col_wrap) begin
				raster.x <= '0;
				raster.y <= (raster.y == coord_t'(V_TOTAL - 1)) ? '0 : raster.y + 1'b1;
			end else begin
				raster.x <= raster.x + 1'b1;
			end
			sync.hsync <= !(raster.x >= HS_START && raster.x < HS_START + H_SYNC);
			sync.vsync <= !(raster.y >= VS_START && raster.y < VS_START + V_SYNC);
		end
	end

	assign active = (raster.x < H_ACTIVE) && (raster.y < V_ACTIVE); // visible area

endmodule

`default_nettype wire

// File: pong_pkg.sv
`default_nettype none

package pong_pkg;

	typedef logic [9:0] coord_t; // screen coordinate

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pos_t;

	typedef struct packed {
		logic up_n; // pressed when low
		logic down_n;
	} paddle_keys_t;

	typedef logic [9:0] score_t;
	typedef logic [6:0] seg_t; // segment g..a, lit when low

	typedef struct packed {
		logic hsync; // active low
		logic vsync;
	} sync_t;

	// 640x480 at 60 Hz timing
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT = 16;
	localparam int H_SYNC = 96;
	localparam int H_TOTAL = 800;
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT = 10;
	localparam int V_SYNC = 2;
	localparam int V_TOTAL = 525;

	localparam int BALL_HALF = 4;
	localparam int PADDLE_HALF_H = 42;
	localparam int PADDLE_HALF_W = 2;
	localparam int PADDLE_ZONE = 14; // half height of the middle third
	localparam int RIGHT_PADDLE_X = 580;
	localparam int LEFT_PADDLE_X = 60;
	localparam int SCORE_DIGITS = 3;

	function automatic seg_t seg_encode(input logic [3:0] digit);
		case (digit)
			4'd0: seg_encode = 7'b1000000;
			4'd1: seg_encode = 7'b1111001;
			4'd2: seg_encode = 7'b0100100;
			4'd3: seg_encode = 7'b0110000;
			4'd4: seg_encode = 7'b0011001;
			4'd5: seg_encode = 7'b0010010;
			4'd6: seg_encode = 7'b0000010;
			4'd7: seg_encode = 7'b1111000;
			4'd8: seg_encode = 7'b0000000;
			4'd9: seg_encode = 7'b0011000;
			default: seg_encode = 7'b1111111; // blank for non-bcd
		endcase
	endfunction

endpackage

`default_nettype wire
